// File: logic/bp_pkg.sv
package bp_pkg;

	//////////////////////////////
	// table geometry
	//////////////////////////////

	// halfword pc
	localparam int PC_W     = 11;
	// pc[3:0] selects the set
	localparam int SET_W    = 4;
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;
	localparam int WAY_W    = 2;
	// pc[10:4] is the tag
	localparam int TAG_W    = 7;
	// isr flag on top of the tag
	localparam int KEY_W    = 8;
	localparam int ENTRY_W  = 22;
	localparam int LINE_W   = 88;

	// entry layout, valid | key | target | counter
	localparam int VALID_BIT = 21;
	localparam int KEY_MSB   = 20;
	localparam int KEY_LSB   = 13;
	localparam int TGT_MSB   = 12;
	localparam int TGT_LSB   = 2;
	localparam int CNT_MSB   = 1;
	localparam int CNT_LSB   = 0;

	// initial counter states
	localparam logic [1:0] CNT_WEAK_NT  = 2'b01;
	localparam logic [1:0] CNT_STRONG_T = 2'b11;

	// exe correction codes for the next pc select
	localparam logic [1:0] CORR_NONE = 2'b00;
	localparam logic [1:0] CORR_CNI  = 2'b10;
	localparam logic [1:0] CORR_PBT  = 2'b11;

	// beq bne blt bge bltu bgeu, msb first
	localparam int BTYPE_W  = 6;
	// beqz bnez, msb first
	localparam int CBTYPE_W = 2;

endpackage

// File: logic/bht_lookup_if.sv
`timescale 1ns/1ps

// one table lookup, request in and result out
interface bht_lookup_if;
	import bp_pkg::*;

	// request side
	logic [SET_W-1:0]   set;
	logic [KEY_W-1:0]   key;

	// result side
	logic               hit;
	logic [WAY_W-1:0]   way;
	// matching entry, all zeros on a miss
	logic [ENTRY_W-1:0] entry;

	// pipeline stage asking for a lookup
	modport requester (output set, key, input hit, way, entry);
	// table answering it
	modport table_side (input set, key, output hit, way, entry);

endinterface

// File: logic/bht_way_match.sv
`timescale 1ns/1ps

// tag compare across the four ways of one set
module bht_way_match (
	input  logic [bp_pkg::KEY_W-1:0]  key,
	input  logic [bp_pkg::LINE_W-1:0] line,
	bht_lookup_if.table_side          lk
);
	import bp_pkg::*;

	// per way hit, valid AND key compare
	logic [NUM_WAYS-1:0] way_hit;

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = line[w*ENTRY_W + VALID_BIT] &&
				(line[w*ENTRY_W + KEY_LSB +: KEY_W] == key);
		end
	end

	// pick the matching way
	// allocation only writes on a miss so at most one way hits
	always_comb begin
		lk.hit   = 1'b0;
		lk.way   = '0;
		lk.entry = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_hit[w] && !lk.hit) begin
				lk.hit   = 1'b1;
				lk.way   = WAY_W'(w);
				lk.entry = line[w*ENTRY_W +: ENTRY_W];
			end
		end
	end

endmodule

// File: logic/bht_store.sv
`timescale 1ns/1ps

// branch history table storage
// 16 sets of 4 ways, one line per set
// three combinational read ports and one write port
module bht_store (
	input  logic                       CLK,
	input  logic                       nrst,
	input  logic                       en,
	input  logic                       stall,

	// read ports for fetch, decode and execute
	bht_lookup_if.table_side           if_lk,
	bht_lookup_if.table_side           id_lk,
	bht_lookup_if.table_side           exe_lk,

	// write port
	input  logic                       wr_en,
	// take the way from the set's fifo counter
	input  logic                       alloc,
	input  logic [bp_pkg::SET_W-1:0]   wr_set,
	input  logic [bp_pkg::WAY_W-1:0]   wr_way,
	input  logic [bp_pkg::ENTRY_W-1:0] wr_entry
);
	import bp_pkg::*;

	//////////////////////////////
	// storage
	//////////////////////////////

	// one line holds the four ways of a set
	// way 0 sits in the low bits
	logic [LINE_W-1:0] lines [NUM_SETS];

	// fifo victim pointer per set
	logic [WAY_W-1:0]  fifo_cnt [NUM_SETS];

	// way actually written this cycle
	logic [WAY_W-1:0]  wr_way_sel;

	// write only moves when the pipeline does
	logic              wr_fire;

	//////////////////////////////
	// read ports
	//////////////////////////////

	logic [LINE_W-1:0] if_line;
	logic [LINE_W-1:0] id_line;
	logic [LINE_W-1:0] exe_line;

	// set select, no read latency
	assign if_line  = lines[if_lk.set];
	assign id_line  = lines[id_lk.set];
	assign exe_line = lines[exe_lk.set];

	// fetch stage compare
	bht_way_match u_if_match (
		.key  (if_lk.key),
		.line (if_line),
		.lk   (if_lk)
	);

	// decode stage compare
	bht_way_match u_id_match (
		.key  (id_lk.key),
		.line (id_line),
		.lk   (id_lk)
	);

	// execute stage compare
	bht_way_match u_exe_match (
		.key  (exe_lk.key),
		.line (exe_line),
		.lk   (exe_lk)
	);

	//////////////////////////////
	// write port
	//////////////////////////////

	// allocation ignores wr_way and uses the fifo pointer
	assign wr_way_sel = alloc ? fifo_cnt[wr_set] : wr_way;
	assign wr_fire    = wr_en && en && !stall;

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			// all entries invalid, pointers back at way 0
			for (int s = 0; s < NUM_SETS; s++) begin
				lines[s]    <= '0;
				fifo_cnt[s] <= '0;
			end
		end else if (wr_fire) begin
			// only the selected way of the line changes
			lines[wr_set][wr_way_sel*ENTRY_W +: ENTRY_W] <= wr_entry;
			// oldest way becomes the next victim
			if (alloc) begin
				fifo_cnt[wr_set] <= fifo_cnt[wr_set] + 1'b1;
			end
		end
	end

endmodule

// File: logic/bht_update.sv
`timescale 1ns/1ps

// picks the single table write of a cycle
// priority is allocate, then retarget, then counter training
module bht_update (
	input  logic                        en,
	input  logic                        stall,

	bht_lookup_if.requester             id_lk,
	bht_lookup_if.requester             exe_lk,

	// decode stage info
	input  logic                        id_is_jump,
	input  logic                        id_is_btype,
	// register indirect jump (jalr, c.jr, c.jalr)
	input  logic                        id_sel_opBR,
	input  logic [bp_pkg::PC_W-1:0]     id_branchtarget,

	// execute stage outcome
	input  logic                        exe_active,
	input  logic                        taken,

	// write port to the table
	output logic                        wr_en,
	output logic                        alloc,
	output logic [bp_pkg::SET_W-1:0]    wr_set,
	output logic [bp_pkg::WAY_W-1:0]    wr_way,
	output logic [bp_pkg::ENTRY_W-1:0]  wr_entry
);
	import bp_pkg::*;

	logic               do_alloc;
	logic               do_retgt;
	logic               do_train;
	logic [1:0]         cnt;
	logic [1:0]         cnt_next;
	logic [ENTRY_W-1:0] new_entry;
	logic [ENTRY_W-1:0] retgt_entry;
	logic [ENTRY_W-1:0] train_entry;

	// new branch or jump not yet in the table
	assign do_alloc = (id_is_btype || id_is_jump) && !id_lk.hit;

	// indirect jump whose stored target went stale
	assign do_retgt = id_is_jump && id_sel_opBR && id_lk.hit &&
		(id_lk.entry[TGT_MSB:TGT_LSB] != id_branchtarget);

	// saturating counter step from the resolved outcome
	assign cnt = exe_lk.entry[CNT_MSB:CNT_LSB];

	always_comb begin
		cnt_next = cnt;
		if (taken && cnt != 2'b11) begin
			cnt_next = cnt + 2'b01;
		end else if (!taken && cnt != 2'b00) begin
			cnt_next = cnt - 2'b01;
		end
	end

	// skip the write when the counter is already saturated
	assign do_train = exe_active && exe_lk.hit && (cnt_next != cnt);

	// candidate entries
	always_comb begin
		new_entry                   = '0;
		new_entry[VALID_BIT]        = 1'b1;
		new_entry[KEY_MSB:KEY_LSB]  = id_lk.key;
		new_entry[TGT_MSB:TGT_LSB]  = id_branchtarget;
		// jumps start strongly taken, branches weakly not taken
		new_entry[CNT_MSB:CNT_LSB]  = id_is_jump ? CNT_STRONG_T : CNT_WEAK_NT;

		retgt_entry                  = id_lk.entry;
		retgt_entry[TGT_MSB:TGT_LSB] = id_branchtarget;

		train_entry                  = exe_lk.entry;
		train_entry[CNT_MSB:CNT_LSB] = cnt_next;
	end

	// write select, training is the fallback
	always_comb begin
		wr_set   = exe_lk.set;
		wr_way   = exe_lk.way;
		wr_entry = train_entry;
		if (do_alloc) begin
			wr_set   = id_lk.set;
			wr_way   = id_lk.way;
			wr_entry = new_entry;
		end else if (do_retgt) begin
			wr_set   = id_lk.set;
			wr_way   = id_lk.way;
			wr_entry = retgt_entry;
		end
	end

	assign alloc = do_alloc;
	assign wr_en = en && !stall && (do_alloc || do_retgt || do_train);

endmodule

// File: logic/branch_resolve.sv
`timescale 1ns/1ps

// execute stage branch resolution
// compares the alu outcome with the stored prediction
module branch_resolve (
	bht_lookup_if.requester             exe_lk,

	// alu flags
	input  logic                        exe_z,
	input  logic                        exe_less,
	input  logic [bp_pkg::BTYPE_W-1:0]  exe_btype,
	input  logic [bp_pkg::CBTYPE_W-1:0] exe_c_btype,

	output logic                        exe_active,
	output logic                        taken,
	output logic                        mispredict,
	output logic [1:0]                  exe_correction,
	// predicted branch target
	output logic [bp_pkg::PC_W-1:0]     exe_PBT,
	// correct next instruction
	output logic [bp_pkg::PC_W-1:0]     exe_CNI
);
	import bp_pkg::*;

	logic predict;
	logic is_compressed;

	// any branch type present in execute
	assign exe_active    = |exe_btype || |exe_c_btype;
	assign is_compressed = |exe_c_btype;

	// outcome per branch type
	// signed and unsigned compares share the less flag
	assign taken = (exe_btype[5] &&  exe_z)    ||
	               (exe_btype[4] && !exe_z)    ||
	               (exe_btype[3] &&  exe_less) ||
	               (exe_btype[2] && !exe_less) ||
	               (exe_btype[1] &&  exe_less) ||
	               (exe_btype[0] && !exe_less) ||
	               (exe_c_btype[1] &&  exe_z)  ||
	               (exe_c_btype[0] && !exe_z);

	// counter msb is the prediction, zero on a miss
	assign predict    = exe_lk.entry[CNT_MSB];
	assign mispredict = exe_active && (predict != taken);

	// wrongly taken goes back to the fall through pc
	// wrongly not taken jumps to the stored target
	always_comb begin
		exe_correction = CORR_NONE;
		if (mispredict) begin
			exe_correction = taken ? CORR_PBT : CORR_CNI;
		end
	end

	assign exe_PBT = exe_lk.entry[TGT_MSB:TGT_LSB];

	// pc rebuilt from the stored tag and the set
	// step is one halfword for a compressed branch, two otherwise
	assign exe_CNI = {exe_lk.entry[KEY_MSB-1:KEY_LSB], exe_lk.set} +
		(is_compressed ? PC_W'(1) : PC_W'(2));

endmodule

// File: logic/flush_ctrl.sv
`timescale 1ns/1ps

// flush generation and decode jump check
module flush_ctrl (
	input  logic                    CLK,
	input  logic                    nrst,
	input  logic                    en,
	input  logic                    stall,

	bht_lookup_if.requester         id_lk,
	input  logic                    id_is_jump,
	input  logic                    id_sel_opBR,
	input  logic [bp_pkg::PC_W-1:0] id_branchtarget,

	input  logic                    mispredict,

	output logic                    flush,
	output logic                    id_jump_in_bht
);
	import bp_pkg::*;

	// delayed flush state
	logic flush_q;
	logic flush_d;
	logic tgt_match;
	logic jump_unknown;

	assign tgt_match = id_lk.entry[TGT_MSB:TGT_LSB] == id_branchtarget;

	// direct jump missing, or indirect jump hit with a stale target
	assign jump_unknown = id_is_jump &&
		((!id_sel_opBR && !id_lk.hit) || (id_sel_opBR && id_lk.hit && !tgt_match));

	// no new request while the delayed flush is out
	assign flush_d = !flush_q && (mispredict || jump_unknown);
	assign flush   = flush_q || mispredict;

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			flush_q <= 1'b0;
		end else if (en && !stall) begin
			flush_q <= flush_d;
		end
	end

	// decode may use the table target for this jump
	assign id_jump_in_bht = id_is_jump && id_lk.hit && (!id_sel_opBR || tgt_match);

endmodule

// File: logic/branch_predict_unit.sv
`timescale 1ns/1ps

// branch prediction unit top
// next pc select uses {exe_correction, if_prediction}
module branch_predict_unit (
	input  logic                        CLK,
	input  logic                        nrst,
	input  logic                        en,
	// isr flag becomes the key msb
	input  logic                        ISR_running,
	input  logic                        stall,

	input  logic [bp_pkg::PC_W-1:0]     if_PC,

	input  logic [bp_pkg::PC_W-1:0]     id_PC,
	input  logic [bp_pkg::PC_W-1:0]     id_branchtarget,
	input  logic                        id_is_jump,
	input  logic                        id_is_btype,
	input  logic                        id_sel_opBR,

	input  logic [bp_pkg::PC_W-1:0]     exe_PC,
	input  logic                        exe_z,
	input  logic                        exe_less,
	input  logic [bp_pkg::BTYPE_W-1:0]  exe_btype,
	input  logic [bp_pkg::CBTYPE_W-1:0] exe_c_btype,

	output logic                        if_prediction,
	output logic [1:0]                  exe_correction,
	output logic                        flush,
	output logic                        id_jump_in_bht,
	output logic [bp_pkg::PC_W-1:0]     if_PBT,
	output logic [bp_pkg::PC_W-1:0]     exe_PBT,
	output logic [bp_pkg::PC_W-1:0]     exe_CNI
);
	import bp_pkg::*;

	bht_lookup_if if_lk ();
	bht_lookup_if id_lk ();
	bht_lookup_if exe_lk ();

	// write port
	logic               wr_en;
	logic               alloc;
	logic [SET_W-1:0]   wr_set;
	logic [WAY_W-1:0]   wr_way;
	logic [ENTRY_W-1:0] wr_entry;

	// resolve results
	logic exe_active;
	logic taken;
	logic mispredict;

	//////////////////////////////
	// lookup requests
	//////////////////////////////

	// pc[3:0] is the set, pc[10:4] the tag
	assign if_lk.set  = if_PC[SET_W-1:0];
	assign if_lk.key  = {ISR_running, if_PC[PC_W-1:SET_W]};
	assign id_lk.set  = id_PC[SET_W-1:0];
	assign id_lk.key  = {ISR_running, id_PC[PC_W-1:SET_W]};
	assign exe_lk.set = exe_PC[SET_W-1:0];
	assign exe_lk.key = {ISR_running, exe_PC[PC_W-1:SET_W]};

	// fetch prediction straight from the hit entry
	assign if_prediction = if_lk.entry[CNT_MSB];
	assign if_PBT        = if_lk.entry[TGT_MSB:TGT_LSB];

	bht_store u_store (
		.CLK (CLK), .nrst (nrst), .en (en), .stall (stall),
		.if_lk (if_lk), .id_lk (id_lk), .exe_lk (exe_lk),
		.wr_en (wr_en), .alloc (alloc), .wr_set (wr_set),
		.wr_way (wr_way), .wr_entry (wr_entry)
	);

	bht_update u_update (
		.en (en), .stall (stall), .id_lk (id_lk), .exe_lk (exe_lk),
		.id_is_jump (id_is_jump), .id_is_btype (id_is_btype),
		.id_sel_opBR (id_sel_opBR), .id_branchtarget (id_branchtarget),
		.exe_active (exe_active), .taken (taken),
		.wr_en (wr_en), .alloc (alloc), .wr_set (wr_set),
		.wr_way (wr_way), .wr_entry (wr_entry)
	);

	branch_resolve u_resolve (
		.exe_lk (exe_lk), .exe_z (exe_z), .exe_less (exe_less),
		.exe_btype (exe_btype), .exe_c_btype (exe_c_btype),
		.exe_active (exe_active), .taken (taken), .mispredict (mispredict),
		.exe_correction (exe_correction), .exe_PBT (exe_PBT), .exe_CNI (exe_CNI)
	);

	flush_ctrl u_flush (
		.CLK (CLK), .nrst (nrst), .en (en), .stall (stall),
		.id_lk (id_lk), .id_is_jump (id_is_jump), .id_sel_opBR (id_sel_opBR),
		.id_branchtarget (id_branchtarget), .mispredict (mispredict),
		.flush (flush), .id_jump_in_bht (id_jump_in_bht)
	);

endmodule

// File: tests/bp_props.sv
`timescale 1ns/1ps

// flush control properties, bound into flush_ctrl
module bp_props (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic stall,
	input logic mispredict,
	input logic flush_q,
	input logic flush,
	input logic id_jump_in_bht,
	input logic id_hit
);

	// a mispredict outside a running flush starts the delayed flush
	// a second one inside the flush window is already covered
	mispredict_then_flush: assert property (@(posedge CLK) disable iff (!nrst)
		mispredict && en && !stall && !flush_q |=> flush)
		else $error("mispredict was not followed by a flush cycle");

	// flush state comes out of reset cleared
	quiet_after_reset: assert property (@(posedge CLK) $rose(nrst) |-> !flush)
		else $error("flush was high on the first cycle after reset");

	// the jump known flag needs a decode hit
	known_jump_hits: assert property (@(posedge CLK) disable iff (!nrst)
		id_jump_in_bht |-> id_hit)
		else $error("id_jump_in_bht was high on a decode miss");

endmodule

bind flush_ctrl bp_props u_props (
	.CLK            (CLK),
	.nrst           (nrst),
	.en             (en),
	.stall          (stall),
	.mispredict     (mispredict),
	.flush_q        (flush_q),
	.flush          (flush),
	.id_jump_in_bht (id_jump_in_bht),
	.id_hit         (id_lk.hit)
);

// File: tests/bp_checker.sv
`timescale 1ns/1ps

// compares the dut outputs with the expected values of the current row
// samples on the falling edge, half a cycle after the row was driven
module bp_checker (
	input  logic                    CLK,
	input  logic                    check_en,
	// exe_CNI only means something with a branch in execute
	input  logic                    chk_cni,

	// dut outputs
	input  logic                    if_prediction,
	input  logic [bp_pkg::PC_W-1:0] if_PBT,
	input  logic [1:0]              exe_correction,
	input  logic [bp_pkg::PC_W-1:0] exe_CNI,
	input  logic [bp_pkg::PC_W-1:0] exe_PBT,
	input  logic                    flush,
	input  logic                    id_jump_in_bht,

	// expected values
	input  logic                    exp_pred,
	input  logic [bp_pkg::PC_W-1:0] exp_pbt,
	input  logic [1:0]              exp_corr,
	input  logic [bp_pkg::PC_W-1:0] exp_cni,
	input  logic [bp_pkg::PC_W-1:0] exp_epbt,
	input  logic                    exp_flush,
	input  logic                    exp_jib,

	output int                      checks,
	output int                      errors
);

	initial begin
		checks = 0;
		errors = 0;
	end

	// one compare, x or z on the dut side also counts as wrong
	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	always @(negedge CLK) begin
		if (check_en) begin
			compare_value("if_prediction", 32'(exp_pred), 32'(if_prediction));
			compare_value("if_PBT", 32'(exp_pbt), 32'(if_PBT));
			compare_value("exe_correction", 32'(exp_corr), 32'(exe_correction));
			compare_value("exe_PBT", 32'(exp_epbt), 32'(exe_PBT));
			compare_value("flush", 32'(exp_flush), 32'(flush));
			compare_value("id_jump_in_bht", 32'(exp_jib), 32'(id_jump_in_bht));
			if (chk_cni) begin
				compare_value("exe_CNI", 32'(exp_cni), 32'(exe_CNI));
			end
		end
	end

endmodule

// File: tests/tb_branch_predict_unit.sv
`timescale 1ns/1ps

module tb_branch_predict_unit;
	import bp_pkg::*;

	// one table row, packed fields are split up when driven
	typedef struct packed {
		logic [1:0]      ctl;    // stall, isr
		logic [PC_W-1:0] if_pc;
		logic [PC_W-1:0] id_pc;
		logic [PC_W-1:0] id_tgt;
		logic [2:0]      idf;    // jump, btype, opbr
		logic [PC_W-1:0] exe_pc;
		logic [1:0]      alu;    // z, less
		logic [7:0]      types;  // btype then c_btype
		logic [2:0]      ef;     // prediction, flush, jump in bht
		logic [PC_W-1:0] pbt;
		logic [1:0]      corr;
		logic [PC_W-1:0] cni;
		// stored target seen by execute
		logic [PC_W-1:0] epbt;
	} row_t;

	logic                CLK;
	logic                nrst;
	logic                en;
	logic                ISR_running;
	logic                stall;
	logic [PC_W-1:0]     if_PC;
	logic [PC_W-1:0]     id_PC;
	logic [PC_W-1:0]     id_branchtarget;
	logic                id_is_jump;
	logic                id_is_btype;
	logic                id_sel_opBR;
	logic [PC_W-1:0]     exe_PC;
	logic                exe_z;
	logic                exe_less;
	logic [BTYPE_W-1:0]  exe_btype;
	logic [CBTYPE_W-1:0] exe_c_btype;
	logic                if_prediction;
	logic [1:0]          exe_correction;
	logic                flush;
	logic                id_jump_in_bht;
	logic [PC_W-1:0]     if_PBT;
	logic [PC_W-1:0]     exe_PBT;
	logic [PC_W-1:0]     exe_CNI;

	// expected values of the row in flight
	logic                check_en;
	logic                chk_cni;
	logic                exp_pred;
	logic [PC_W-1:0]     exp_pbt;
	logic [1:0]          exp_corr;
	logic [PC_W-1:0]     exp_cni;
	logic [PC_W-1:0]     exp_epbt;
	logic                exp_flush;
	logic                exp_jib;

	row_t rows[$];
	int   checks;
	int   errors;
	int   cycles;
	int   limit;

	branch_predict_unit DUT (.*);

	bp_checker u_checker (
		.CLK (CLK), .check_en (check_en), .chk_cni (chk_cni),
		.if_prediction (if_prediction), .if_PBT (if_PBT),
		.exe_correction (exe_correction), .exe_CNI (exe_CNI), .exe_PBT (exe_PBT),
		.flush (flush), .id_jump_in_bht (id_jump_in_bht),
		.exp_pred (exp_pred), .exp_pbt (exp_pbt), .exp_corr (exp_corr),
		.exp_cni (exp_cni), .exp_epbt (exp_epbt),
		.exp_flush (exp_flush), .exp_jib (exp_jib),
		.checks (checks), .errors (errors)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic add_row(input logic [1:0] ctl, input logic [PC_W-1:0] if_pc,
		input logic [PC_W-1:0] id_pc, input logic [PC_W-1:0] id_tgt,
		input logic [2:0] idf, input logic [PC_W-1:0] exe_pc, input logic [1:0] alu,
		input logic [7:0] types, input logic [2:0] ef, input logic [PC_W-1:0] pbt,
		input logic [1:0] corr, input logic [PC_W-1:0] cni,
		input logic [PC_W-1:0] epbt);
		rows.push_back('{ctl, if_pc, id_pc, id_tgt, idf, exe_pc, alu, types,
			ef, pbt, corr, cni, epbt});
	endtask

	//////////////////////////////
	// stimulus and expected rows
	//////////////////////////////

	// fetch pcs in set f get a random tag, set f is never written
	task automatic build_table();
		// reset state
		add_row(2'b00, 11'h123, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		// branch at 123 allocated weakly not taken, fetch in the same cycle misses
		add_row(2'b00, 11'h123, 11'h123, 11'h050, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		// fetch hits not taken, direct jump at 245 misses in decode
		add_row(2'b00, 11'h123, 11'h245, 11'h300, 3'b100, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h050, 2'b00, 11'h000, 11'h000);
		// jump predicts taken, delayed flush from the unknown jump
		add_row(2'b00, 11'h245, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b110, 11'h300, 2'b00, 11'h000, 11'h000);
		// beq taken on weak not taken, pbt correction, full size step
		add_row(2'b00, 11'h00f, 11'h000, 11'h000, 3'b000, 11'h123, 2'b10, 8'b100000_00,
			3'b010, 11'h000, 2'b11, 11'h125, 11'h050);
		// second flush cycle, trained entry now predicts taken
		add_row(2'b00, 11'h123, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b110, 11'h050, 2'b00, 11'h000, 11'h000);
		// c.bnez taken as predicted, compressed step
		add_row(2'b00, 11'h00f, 11'h000, 11'h000, 3'b000, 11'h123, 2'b00, 8'b000000_01,
			3'b000, 11'h000, 2'b00, 11'h124, 11'h050);
		// bne not taken on strong taken, cni correction
		add_row(2'b00, 11'h00f, 11'h000, 11'h000, 3'b000, 11'h123, 2'b10, 8'b010000_00,
			3'b010, 11'h000, 2'b10, 11'h125, 11'h050);
		add_row(2'b00, 11'h123, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b110, 11'h050, 2'b00, 11'h000, 11'h000);
		// five branches into set 6
		add_row(2'b00, 11'h00f, 11'h016, 11'h101, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h016, 11'h026, 11'h102, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h101, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h00f, 11'h036, 11'h103, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h00f, 11'h046, 11'h104, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		// fifo wraps to way 0, old entry still readable this cycle
		add_row(2'b00, 11'h016, 11'h056, 11'h105, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h101, 2'b00, 11'h000, 11'h000);
		// first branch evicted
		add_row(2'b00, 11'h016, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		// indirect jump at 3a7 allocated, a miss does not flush
		add_row(2'b00, 11'h056, 11'h3a7, 11'h200, 3'b101, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h105, 2'b00, 11'h000, 11'h000);
		// stale target, retargeted with a delayed flush
		add_row(2'b00, 11'h3a7, 11'h3a7, 11'h2c0, 3'b101, 11'h000, 2'b00, 8'h00,
			3'b100, 11'h200, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h3a7, 11'h3a7, 11'h2c0, 3'b101, 11'h000, 2'b00, 8'h00,
			3'b111, 11'h2c0, 2'b00, 11'h000, 11'h000);
		// direct jump miss flushes one cycle later
		add_row(2'b00, 11'h00f, 11'h4c8, 11'h0a0, 3'b100, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h4c8, 11'h4c8, 11'h0a0, 3'b100, 11'h000, 2'b00, 8'h00,
			3'b111, 11'h0a0, 2'b00, 11'h000, 11'h000);
		// stalled branch is not written
		add_row(2'b10, 11'h519, 11'h519, 11'h0f0, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h519, 11'h519, 11'h0f0, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h519, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h0f0, 2'b00, 11'h000, 11'h000);
		// isr key misses the normal entry and gets its own
		add_row(2'b01, 11'h519, 11'h519, 11'h0f8, 3'b010, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h000, 2'b00, 11'h000, 11'h000);
		add_row(2'b01, 11'h519, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h0f8, 2'b00, 11'h000, 11'h000);
		add_row(2'b00, 11'h519, 11'h000, 11'h000, 3'b000, 11'h000, 2'b00, 8'h00,
			3'b000, 11'h0f0, 2'b00, 11'h000, 11'h000);
	endtask

	//////////////////////////////
	// run
	//////////////////////////////

	initial begin
		row_t r;
		nrst = 1'b0;
		en = 1'b1;
		ISR_running = 1'b0;
		stall = 1'b0;
		if_PC = '0;
		id_PC = '0;
		id_branchtarget = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		id_sel_opBR = 1'b0;
		exe_PC = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = '0;
		exe_c_btype = '0;
		check_en = 1'b0;
		chk_cni = 1'b0;
		{exp_pred, exp_pbt, exp_corr, exp_cni, exp_epbt, exp_flush, exp_jib} = '0;
		void'($urandom(32'hf9c7_41c8));
		build_table();
		// two cycles a row plus margin for reset
		limit = rows.size() * 2 + 20;
		repeat (3) @(posedge CLK);
		nrst <= 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			@(posedge CLK);
			stall <= r.ctl[1];
			ISR_running <= r.ctl[0];
			if_PC <= (r.if_pc[3:0] == 4'hf) ? {7'($urandom), 4'hf} : r.if_pc;
			id_PC <= r.id_pc;
			id_branchtarget <= r.id_tgt;
			id_is_jump <= r.idf[2];
			id_is_btype <= r.idf[1];
			id_sel_opBR <= r.idf[0];
			exe_PC <= r.exe_pc;
			exe_z <= r.alu[1];
			exe_less <= r.alu[0];
			exe_btype <= r.types[7:2];
			exe_c_btype <= r.types[1:0];
			exp_pred <= r.ef[2];
			exp_flush <= r.ef[1];
			exp_jib <= r.ef[0];
			exp_pbt <= r.pbt;
			exp_corr <= r.corr;
			exp_cni <= r.cni;
			exp_epbt <= r.epbt;
			chk_cni <= |r.types;
			check_en <= 1'b1;
		end
		@(posedge CLK);
		check_en <= 1'b0;
		@(posedge CLK);
		$display("rows %0d checks %0d errors %0d", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// run limit
	initial begin
		cycles = 0;
		@(posedge CLK);
		while (cycles < limit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("run timed out after %0d cycles", cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: compile.f
logic/bp_pkg.sv
logic/bht_lookup_if.sv
logic/bht_way_match.sv
logic/bht_store.sv
logic/bht_update.sv
logic/branch_resolve.sv
logic/flush_ctrl.sv
logic/branch_predict_unit.sv
tests/bp_props.sv
tests/bp_checker.sv
tests/tb_branch_predict_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the branch prediction unit testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_branch_predict_unit
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f compile.f \
	-Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$SIM_LOG"
	echo "simulation exited with an error status"
	exit 1
fi
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
	echo "result: FAIL"
	exit 1
fi
echo "result: PASS"
exit 0
